/* common/sha_pkg.sv */
`default_nettype none

package sha_pkg;

  typedef logic [31:0] word_t;                 // One SHA-256 word
  typedef logic [7:0][31:0] hash_state_t;      // Working variables, a in word 7 and h in word 0
  typedef logic [15:0][31:0] window_t;         // Message history, word 15 the oldest

  localparam int PRE_ROUNDS = 15;              // Rounds with constant or generated message words
  localparam int NUM_ROUNDS = 64;              // Full SHA-256 compression
  localparam int CORE_LATENCY = NUM_ROUNDS;    // One register per round, feed-forward is combinational
  localparam word_t PAD_WORD = 32'h8000_0000;  // Leading one bit of the padding
  localparam word_t MSG_LEN_BITS = 32'd640;    // 80-byte header length in bits

  localparam word_t ROUND_K [0:NUM_ROUNDS-1] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  function automatic word_t k_const(input int round);
    return ROUND_K[round];                     // Evaluated at elaboration for each stage
  endfunction

  function automatic word_t rotr(input word_t x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic word_t big_sigma0(input word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic word_t big_sigma1(input word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic word_t small_sigma0(input word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic word_t small_sigma1(input word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  // One compression round, shared by the pre-pipeline and the schedule stages
  function automatic hash_state_t sha_round(input hash_state_t s, input word_t k,
                                            input word_t w);
    word_t t1;
    word_t t2;
    word_t ch;
    word_t maj;
    ch = (s[3] & s[2]) ^ (~s[3] & s[1]);           // Choose f or g by e
    maj = (s[7] & s[6]) ^ (s[7] & s[5]) ^ (s[6] & s[5]);  // Majority of a, b, c
    t1 = s[0] + big_sigma1(s[3]) + ch + k + w;       // h + Sigma1(e) + Ch + K + W
    t2 = big_sigma0(s[7]) + maj;
    return {t1 + t2, s[7], s[6], s[5], s[4] + t1, s[3], s[2], s[1]};  // Rotate the variables down
  endfunction

endpackage

`default_nettype wire

/* source/nonce_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module nonce_counter (
  input  logic           clk,
  input  logic           restart_i,  // First item of a new block seen one stage earlier
  input  logic           step_i,     // Any valid item one stage earlier
  output sha_pkg::word_t count_o     // Nonce of the item now at this stage
);

  sha_pkg::word_t count_q;

  // The value only matters once a new-block item has passed, so no reset
  always_ff @(posedge clk) begin
    if (restart_i) begin
      count_q <= '0;                  // A new block always starts at nonce 0
    end else if (step_i) begin
      count_q <= count_q + 32'd1;     // Next header in the same block
    end
  end

  assign count_o = count_q;           // Registered, so it lines up one stage after the strobe

endmodule

`default_nettype wire

/* sha_pre/sha_pre_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module sha_pre_stage #(
  parameter int ROUND = 0                  // Round index selecting the constant
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 valid_i,
  input  logic                 newblock_i,
  input  sha_pkg::hash_state_t state_i,
  input  sha_pkg::word_t       w_i,        // Message word for this round
  input  sha_pkg::hash_state_t midstate_i,
  output logic                 valid_o,
  output logic                 newblock_o,
  output sha_pkg::hash_state_t state_o,
  output sha_pkg::hash_state_t midstate_o
);

  localparam sha_pkg::word_t K = sha_pkg::k_const(ROUND);  // Fixed per stage

  sha_pkg::hash_state_t state_next;

  assign state_next = sha_pkg::sha_round(state_i, K, w_i);  // Whole round in one cycle

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;                     // In-flight items are dropped
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    newblock_o <= newblock_i;              // Needed by the nonce counters downstream
    state_o    <= state_next;
    midstate_o <= midstate_i;              // Kept for the final feed-forward
  end

endmodule

`default_nettype wire

/* sha_pre/sha_pre_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module sha_pre_pipeline (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 valid_i,
  input  logic                 newblock_i,
  input  sha_pkg::hash_state_t midstate_i,
  input  sha_pkg::word_t       w1_i,        // Merkle root tail
  input  sha_pkg::word_t       w2_i,        // Timestamp
  input  sha_pkg::word_t       w3_i,        // Difficulty target
  output logic                 valid_o,
  output sha_pkg::hash_state_t state_o,
  output sha_pkg::hash_state_t midstate_o,
  output sha_pkg::window_t     history_o,   // W0 in word 15 up to W15 in word 0
  output sha_pkg::word_t       nonce_o
);

  localparam int N = sha_pkg::PRE_ROUNDS;

  logic                 valid_pipe    [0:N];
  logic                 newblock_pipe [0:N-1];  // Stage N has no reader of newblock
  sha_pkg::hash_state_t state_pipe    [0:N];
  sha_pkg::hash_state_t mid_pipe      [0:N];
  sha_pkg::word_t       m_word        [0:N-1];  // Message word per round
  logic [2:0][31:0]     hdr_dly       [0:N-1];  // w1, w2, w3 riding with the item
  sha_pkg::word_t       nonce_s15;

  assign valid_pipe[0]    = valid_i;
  assign newblock_pipe[0] = newblock_i;
  assign state_pipe[0]    = midstate_i;         // The block starts from the midstate
  assign mid_pipe[0]      = midstate_i;

  // Element i holds the header words of the item at stage i + 1
  always_ff @(posedge clk) begin
    hdr_dly[0] <= {w1_i, w2_i, w3_i};
    for (int i = 1; i < N; i++) begin
      hdr_dly[i] <= hdr_dly[i-1];
    end
  end

  assign m_word[0] = w1_i;                      // Round 0 sees the item as it arrives
  assign m_word[1] = hdr_dly[0][1];             // w2 one cycle later
  assign m_word[2] = hdr_dly[1][0];             // w3 two cycles later

  // Restart comes from stage 2 since the counter adds its own register
  nonce_counter u_nonce_s3 (
    .clk       (clk),
    .restart_i (valid_pipe[2] & newblock_pipe[2]),
    .step_i    (valid_pipe[2]),
    .count_o   (m_word[3])
  );

  assign m_word[4] = sha_pkg::PAD_WORD;

  for (genvar n = 5; n < N; n++) begin : g_zero_words
    assign m_word[n] = '0;                      // Padding zeros up to the length word
  end

  for (genvar i = 0; i < N - 1; i++) begin : g_stage
    sha_pre_stage #(.ROUND(i)) u_stage (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .valid_i    (valid_pipe[i]),
      .newblock_i (newblock_pipe[i]),
      .state_i    (state_pipe[i]),
      .w_i        (m_word[i]),
      .midstate_i (mid_pipe[i]),
      .valid_o    (valid_pipe[i+1]),
      .newblock_o (newblock_pipe[i+1]),
      .state_o    (state_pipe[i+1]),
      .midstate_o (mid_pipe[i+1])
    );
  end

  // Round 14 is last, nothing downstream needs its newblock
  sha_pre_stage #(.ROUND(N - 1)) u_stage_last (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_pipe[N-1]),
    .newblock_i (newblock_pipe[N-1]),
    .state_i    (state_pipe[N-1]),
    .w_i        (m_word[N-1]),
    .midstate_i (mid_pipe[N-1]),
    .valid_o    (valid_pipe[N]),
    .newblock_o (),
    .state_o    (state_pipe[N]),
    .midstate_o (mid_pipe[N])
  );

  // Second counter regenerates the nonce for the item leaving the pre-pipeline
  nonce_counter u_nonce_s15 (
    .clk       (clk),
    .restart_i (valid_pipe[N-1] & newblock_pipe[N-1]),
    .step_i    (valid_pipe[N-1]),
    .count_o   (nonce_s15)
  );

  assign history_o[15]   = hdr_dly[N-1][2];     // W0, the oldest word
  assign history_o[14]   = hdr_dly[N-1][1];
  assign history_o[13]   = hdr_dly[N-1][0];
  assign history_o[12]   = nonce_s15;           // W3
  assign history_o[11]   = sha_pkg::PAD_WORD;
  assign history_o[10:1] = '0;                  // W5 to W14
  assign history_o[0]    = sha_pkg::MSG_LEN_BITS;  // W15, the newest word

  assign valid_o    = valid_pipe[N];
  assign state_o    = state_pipe[N];
  assign midstate_o = mid_pipe[N];
  assign nonce_o    = nonce_s15;

endmodule

`default_nettype wire

/* sha_main/sha_sched_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module sha_sched_stage #(
  parameter int ROUND = 15                 // Round index selecting the constant
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 valid_i,
  input  sha_pkg::hash_state_t state_i,
  input  sha_pkg::window_t     window_i,   // Word 0 is W[t], word 15 is W[t-15]
  input  sha_pkg::hash_state_t midstate_i,
  input  sha_pkg::word_t       nonce_i,
  output logic                 valid_o,
  output sha_pkg::hash_state_t state_o,
  output sha_pkg::window_t     window_o,
  output sha_pkg::hash_state_t midstate_o,
  output sha_pkg::word_t       nonce_o
);

  localparam sha_pkg::word_t K = sha_pkg::k_const(ROUND);

  sha_pkg::hash_state_t state_next;
  sha_pkg::word_t       w_next;

  // Round t consumes the newest window word
  assign state_next = sha_pkg::sha_round(state_i, K, window_i[0]);

  // W[t+1] from W[t-1], W[t-6], W[t-14] and W[t-15]
  assign w_next = sha_pkg::small_sigma1(window_i[1])
                + window_i[6]
                + sha_pkg::small_sigma0(window_i[14])
                + window_i[15];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    state_o    <= state_next;
    window_o   <= {window_i[14:0], w_next};  // Oldest word drops out, new word enters at 0
    midstate_o <= midstate_i;                // Passenger for the feed-forward
    nonce_o    <= nonce_i;                   // Passenger reported with the digest
  end

endmodule

`default_nettype wire

/* sha_main/sha_main_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module sha_main_pipeline (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 valid_i,
  input  sha_pkg::hash_state_t state_i,    // State after round 14
  input  sha_pkg::window_t     history_i,  // W0 to W15
  input  sha_pkg::hash_state_t midstate_i,
  input  sha_pkg::word_t       nonce_i,
  output logic                 valid_o,
  output sha_pkg::hash_state_t digest_o,
  output sha_pkg::word_t       nonce_o
);

  localparam int FIRST = sha_pkg::PRE_ROUNDS;
  localparam int M = sha_pkg::NUM_ROUNDS - sha_pkg::PRE_ROUNDS;  // 49 schedule stages

  logic                 valid_pipe [0:M];
  sha_pkg::hash_state_t state_pipe [0:M];
  sha_pkg::window_t     win_pipe   [0:M-1];  // Last stage's window is never consumed
  sha_pkg::hash_state_t mid_pipe   [0:M];
  sha_pkg::word_t       nonce_pipe [0:M];

  assign valid_pipe[0] = valid_i;
  assign state_pipe[0] = state_i;
  assign win_pipe[0]   = history_i;
  assign mid_pipe[0]   = midstate_i;
  assign nonce_pipe[0] = nonce_i;

  for (genvar i = 0; i < M - 1; i++) begin : g_stage
    sha_sched_stage #(.ROUND(FIRST + i)) u_stage (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .valid_i    (valid_pipe[i]),
      .state_i    (state_pipe[i]),
      .window_i   (win_pipe[i]),
      .midstate_i (mid_pipe[i]),
      .nonce_i    (nonce_pipe[i]),
      .valid_o    (valid_pipe[i+1]),
      .state_o    (state_pipe[i+1]),
      .window_o   (win_pipe[i+1]),
      .midstate_o (mid_pipe[i+1]),
      .nonce_o    (nonce_pipe[i+1])
    );
  end

  // Round 63, the schedule word it would produce is not needed
  sha_sched_stage #(.ROUND(sha_pkg::NUM_ROUNDS - 1)) u_stage_last (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_pipe[M-1]),
    .state_i    (state_pipe[M-1]),
    .window_i   (win_pipe[M-1]),
    .midstate_i (mid_pipe[M-1]),
    .nonce_i    (nonce_pipe[M-1]),
    .valid_o    (valid_pipe[M]),
    .state_o    (state_pipe[M]),
    .window_o   (),
    .midstate_o (mid_pipe[M]),
    .nonce_o    (nonce_pipe[M])
  );

  // Feed-forward on the last registers, adding no cycle
  always_comb begin
    for (int j = 0; j < 8; j++) begin
      digest_o[j] = state_pipe[M][j] + mid_pipe[M][j];  // Word-wise, modulo 2^32
    end
  end

  assign valid_o = valid_pipe[M];
  assign nonce_o = nonce_pipe[M];

endmodule

`default_nettype wire

/* source/sha_nonce_core.sv */
`timescale 1ns/10ps
`default_nettype none

module sha_nonce_core (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 valid_i,     // One-cycle strobe, always accepted
  input  logic                 newblock_i,  // Restart the nonce at 0 for this item
  input  sha_pkg::hash_state_t midstate_i,
  input  sha_pkg::word_t       w1_i,
  input  sha_pkg::word_t       w2_i,
  input  sha_pkg::word_t       w3_i,
  output logic                 valid_o,     // CORE_LATENCY cycles after valid_i
  output sha_pkg::hash_state_t digest_o,
  output sha_pkg::word_t       nonce_o
);

  logic                 pre_valid;
  sha_pkg::hash_state_t pre_state;
  sha_pkg::window_t     pre_history;
  sha_pkg::hash_state_t pre_midstate;
  sha_pkg::word_t       pre_nonce;

  // Rounds 0 to 14 with fixed or generated message words
  sha_pre_pipeline u_pre (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .newblock_i (newblock_i),
    .midstate_i (midstate_i),
    .w1_i       (w1_i),
    .w2_i       (w2_i),
    .w3_i       (w3_i),
    .valid_o    (pre_valid),
    .state_o    (pre_state),
    .midstate_o (pre_midstate),
    .history_o  (pre_history),
    .nonce_o    (pre_nonce)
  );

  // Rounds 15 to 63 with the expanding schedule, then the feed-forward
  sha_main_pipeline u_main (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (pre_valid),
    .state_i    (pre_state),
    .history_i  (pre_history),
    .midstate_i (pre_midstate),
    .nonce_i    (pre_nonce),
    .valid_o    (valid_o),
    .digest_o   (digest_o),
    .nonce_o    (nonce_o)
  );

endmodule

`default_nettype wire

/* testbench/sha_nonce_core_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module sha_nonce_core_assertions (
  input logic clk,
  input logic rst_n_i,
  input logic valid_i,
  input logic valid_o
);

  localparam int LAT = sha_pkg::CORE_LATENCY;  // Strobe in to strobe out

  int quiet_cnt;                               // Cycles since reset release, saturating at LAT

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      quiet_cnt <= 0;
    end else if (quiet_cnt < LAT) begin
      quiet_cnt <= quiet_cnt + 1;
    end
  end

  // Every accepted item leaves exactly LAT cycles later unless reset cuts it
  a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_i |-> ##LAT valid_o)
    else $error("valid_o missing %0d cycles after valid_i", LAT);

  // No output without a strobe LAT cycles earlier
  a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_o |-> $past(valid_i, LAT))
    else $error("valid_o without a matching valid_i");

  a_low_in_reset: assert property (@(posedge clk) !rst_n_i |-> !valid_o)
    else $error("valid_o high during reset");

  // Reset empties the pipeline, so the first result needs a full pass after release
  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_o |-> quiet_cnt >= LAT)
    else $error("valid_o less than %0d cycles after reset", LAT);

endmodule

bind sha_nonce_core sha_nonce_core_assertions u_assertions (
  .clk     (clk),
  .rst_n_i (rst_n_i),
  .valid_i (valid_i),
  .valid_o (valid_o)
);

`default_nettype wire

/* testbench/tb_sha_nonce_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sha_nonce_core;

  localparam int REC_WORDS   = 15;                            // Test, gap, newblock, nonce, w1-w3, a-h
  localparam int MAX_REC     = 32;
  localparam int RESET_TEST  = 5;                             // Items of this test are cut by a reset
  localparam int DRAIN_LIMIT = sha_pkg::CORE_LATENCY + 200;   // Cycles allowed for a test to drain

  // Standard SHA-256 round constants
  localparam sha_pkg::word_t K_TAB [0:63] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  logic                 clk = 1'b0;
  logic                 rst_n_i;
  logic                 valid_i;
  logic                 newblock_i;
  sha_pkg::hash_state_t midstate_i;
  sha_pkg::word_t       w1_i;
  sha_pkg::word_t       w2_i;
  sha_pkg::word_t       w3_i;
  logic                 valid_o;
  sha_pkg::hash_state_t digest_o;
  sha_pkg::word_t       nonce_o;

  sha_pkg::word_t       stim_mem [0:REC_WORDS*MAX_REC-1];   // Raw words of the data file
  sha_pkg::hash_state_t exp_digest_q [$];                   // Expected results, oldest first
  sha_pkg::word_t       exp_nonce_q [$];
  int                   exp_cycle_q [$];                    // Cycle count at which each result is due
  sha_pkg::word_t       rule_nonce = '0;                    // Nonce as the nonce rule predicts it
  int                   cycle_cnt = 0;
  int                   check_cnt = 0;
  int                   err_cnt = 0;

  sha_nonce_core uut (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .newblock_i (newblock_i),
    .midstate_i (midstate_i),
    .w1_i       (w1_i),
    .w2_i       (w2_i),
    .w3_i       (w3_i),
    .valid_o    (valid_o),
    .digest_o   (digest_o),
    .nonce_o    (nonce_o)
  );

  always #2 clk = ~clk;                                     // 4 ns period

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic sha_pkg::word_t ror32(input sha_pkg::word_t x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // Second block of the 80-byte header, hashed from the given midstate
  function automatic sha_pkg::hash_state_t reference_hash(input sha_pkg::hash_state_t mid,
      input sha_pkg::word_t m0, input sha_pkg::word_t m1, input sha_pkg::word_t m2,
      input sha_pkg::word_t m3);
    sha_pkg::word_t w [0:63];
    sha_pkg::word_t a, b, c, d, e, f, g, h;
    sha_pkg::word_t t1, t2, s0, s1;
    w[0] = m0;
    w[1] = m1;
    w[2] = m2;
    w[3] = m3;                                              // Nonce word
    w[4] = 32'h8000_0000;                                   // The one bit right after the header
    for (int t = 5; t < 15; t++) w[t] = '0;
    w[15] = 32'd640;                                        // Header length in bits
    for (int t = 16; t < 64; t++) begin
      s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
      s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
    {a, b, c, d, e, f, g, h} = mid;                         // a is the top word
    for (int t = 0; t < 64; t++) begin
      t1 = h + (ror32(e, 6) ^ ror32(e, 11) ^ ror32(e, 25)) + ((e & f) ^ (~e & g))
         + K_TAB[t] + w[t];
      t2 = (ror32(a, 2) ^ ror32(a, 13) ^ ror32(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
      h = g;
      g = f;
      f = e;
      e = d + t1;
      d = c;
      c = b;
      b = a;
      a = t1 + t2;
    end
    return {a + mid[7], b + mid[6], c + mid[5], d + mid[4],
            e + mid[3], f + mid[2], g + mid[1], h + mid[0]};
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "single item";
      2: return "back-to-back stream";
      3: return "new-block restart";
      4: return "spaced strobes";
      5: return "reset with items in flight";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_digest(input sha_pkg::hash_state_t got, input sha_pkg::hash_state_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: digest %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_nonce(input sha_pkg::word_t got, input sha_pkg::word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: nonce %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_cycle(input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("ERR %0t: result at cycle %0d, expected cycle %0d", $time, got, exp);
    end
  endtask

  task automatic idle_inputs();
    valid_i    = 1'b0;
    newblock_i = 1'b0;
  endtask

  // Waits out the gap, strobes one record and queues what should come out
  task automatic drive_item(input int rec);
    int base;
    int gap;
    sha_pkg::hash_state_t mid;
    base = rec * REC_WORDS;
    gap  = int'(stim_mem[base + 1]);
    for (int j = 0; j < 8; j++) mid[7 - j] = stim_mem[base + 7 + j];
    for (int i = 0; i < gap; i++) begin
      @(negedge clk);
      idle_inputs();
    end
    @(negedge clk);
    valid_i    = 1'b1;
    newblock_i = stim_mem[base + 2][0];
    midstate_i = mid;
    w1_i       = stim_mem[base + 4];
    w2_i       = stim_mem[base + 5];
    w3_i       = stim_mem[base + 6];
    if (newblock_i) rule_nonce = '0;
    else rule_nonce = rule_nonce + 32'd1;                  // Only strobed items advance it
    if (rule_nonce !== stim_mem[base + 3]) begin
      err_cnt++;
      $display("Data file record %0d gives nonce %h but the nonce rule gives %h",
               rec, stim_mem[base + 3], rule_nonce);
    end
    exp_digest_q.push_back(reference_hash(mid, w1_i, w2_i, w3_i, rule_nonce));
    exp_nonce_q.push_back(stim_mem[base + 3]);
    exp_cycle_q.push_back(cycle_cnt + sha_pkg::CORE_LATENCY);
  endtask

  task automatic wait_for_results(input int test_id);
    int waited;
    waited = 0;
    while (exp_digest_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_digest_q.size() != 0) begin
      err_cnt++;
      $display("Timeout: test %0d still waits for %0d results after %0d cycles",
               test_id, exp_digest_q.size(), waited);
      exp_digest_q.delete();
      exp_nonce_q.delete();
      exp_cycle_q.delete();
    end
  endtask

  // Reset hits one cycle before the oldest item reaches the output, so none may come out
  task automatic reset_in_flight();
    repeat (sha_pkg::CORE_LATENCY - 4) @(negedge clk);
    rst_n_i = 1'b0;
    exp_digest_q.delete();
    exp_nonce_q.delete();
    exp_cycle_q.delete();
    repeat (2) @(negedge clk);
    rst_n_i = 1'b1;
    repeat (sha_pkg::CORE_LATENCY + 8) @(negedge clk);     // Lost items would have left by now
  endtask

  // Outputs settle after the rising edge, so read them on the falling one
  always @(negedge clk) begin
    if (!rst_n_i && valid_o) begin
      err_cnt++;
      $display("ERR %0t: valid_o high while reset is asserted", $time);
    end else if (valid_o) begin
      if (exp_digest_q.size() == 0) begin
        err_cnt++;
        $display("ERR %0t: valid_o with no item in flight, nonce %h", $time, nonce_o);
      end else begin
        check_digest(digest_o, exp_digest_q.pop_front());
        check_nonce(nonce_o, exp_nonce_q.pop_front());
        check_cycle(cycle_cnt, exp_cycle_q.pop_front());
      end
    end
  end

  initial begin
    int rec;
    int test_id;
    int err_before;
    rst_n_i    = 1'b0;
    valid_i    = 1'b0;
    newblock_i = 1'b0;
    midstate_i = '0;
    w1_i       = '0;
    w2_i       = '0;
    w3_i       = '0;
    rec        = 0;
    $readmemh("testbench/sha_testdata.hex", stim_mem);
    if ($isunknown(stim_mem[0])) begin
      err_cnt++;
      $display("Stimulus file testbench/sha_testdata.hex could not be read");
    end
    repeat (2) @(negedge clk);
    rst_n_i = 1'b1;
    while (rec < MAX_REC && stim_mem[rec * REC_WORDS] != 0) begin
      test_id    = int'(stim_mem[rec * REC_WORDS]);
      err_before = err_cnt;
      while (rec < MAX_REC && stim_mem[rec * REC_WORDS] == test_id) begin
        drive_item(rec);
        rec++;
      end
      @(negedge clk);
      idle_inputs();
      if (test_id == RESET_TEST) reset_in_flight();
      else wait_for_results(test_id);
      $display("Test %0d %s: %s", test_id, test_name(test_id),
               (err_cnt == err_before) ? "ok" : "mismatch");
    end
    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/sha_testdata.hex */
// Each record: test gap newblock nonce w1 w2 w3, then midstate words a to h on the next line
// Gap is idle cycles before the strobe, nonce is the expected nonce, test 0 ends the list
1 0 1 00000000 11223344 55667788 99aabbcc
0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 13579bdf 2468ace0 fedcba98 76543210
2 0 1 00000000 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
2 0 0 00000001 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
2 0 0 00000002 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
2 0 0 00000003 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
2 0 0 00000004 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
3 0 1 00000000 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
3 0 0 00000001 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
3 0 0 00000002 4a5e1e4b 495fab29 1d00ffff
9524c593 05c56713 16e669ba 2d2810a0 07e86e37 2f56a9da cd5bce69 7a78da2d
3 0 1 00000000 d2f2a1c0 5f3e9a10 170d1f8c
3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 6a09e667 bb67ae85
3 0 0 00000001 d2f2a1c0 5f3e9a10 170d1f8c
3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 6a09e667 bb67ae85
3 0 0 00000002 d2f2a1c0 5f3e9a10 170d1f8c
3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 6a09e667 bb67ae85
4 0 1 00000000 11223344 55667788 99aabbcc
0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 13579bdf 2468ace0 fedcba98 76543210
4 3 0 00000001 11223344 55667788 99aabbcc
0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 13579bdf 2468ace0 fedcba98 76543210
4 7 0 00000002 11223344 55667788 99aabbcc
0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 13579bdf 2468ace0 fedcba98 76543210
4 1 0 00000003 11223344 55667788 99aabbcc
0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 13579bdf 2468ace0 fedcba98 76543210
5 0 1 00000000 d2f2a1c0 5f3e9a10 170d1f8c
3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 6a09e667 bb67ae85
5 0 0 00000001 d2f2a1c0 5f3e9a10 170d1f8c
3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 6a09e667 bb67ae85
5 0 0 00000002 d2f2a1c0 5f3e9a10 170d1f8c
3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 6a09e667 bb67ae85
0 0 0 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

/* sha_nonce_core.f */
common/sha_pkg.sv
source/nonce_counter.sv
sha_pre/sha_pre_stage.sv
sha_pre/sha_pre_pipeline.sv
sha_main/sha_sched_stage.sv
sha_main/sha_main_pipeline.sv
source/sha_nonce_core.sv
testbench/sha_nonce_core_assertions.sv
testbench/tb_sha_nonce_core.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_sha_nonce_core
FILELIST   := sha_nonce_core.f
OBJ_DIR    := obj_dir
RUN_ARGS   := +verilator+error+limit+1000
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
